// File: common/prng_consts.svh
`ifndef PRNG_CONSTS_SVH
`define PRNG_CONSTS_SVH

//////////////////////////////////////////////////
// register map
//////////////////////////////////////////////////

// byte offsets on the 5-bit apb address

// bit 0 enable, bits 2:1 round count
`define PRNG_CTRL_ADDR   5'h00
// low half of the staged seed
`define PRNG_SEEDLO_ADDR 5'h04
// high half, writing it loads the seed
`define PRNG_SEEDHI_ADDR 5'h08
// bits 2:0 hold the queue fill level
`define PRNG_STATUS_ADDR 5'h0C
// each read pops one word
`define PRNG_DATA_ADDR   5'h10

//////////////////////////////////////////////////
// generator
//////////////////////////////////////////////////

// words held between generator and bus
`define PRNG_FIFO_DEPTH  4

// galois feedback taps for the 64-bit register
`define PRNG_LFSR_MASK   64'h80000000000019E2

// cipher rounds built into the datapath
`define PRNG_MAX_ROUNDS  3

`endif

// File: common/prngPkg.sv
package prngPkg;

  //////////////////////////////////////////////////
  // apb bus
  //////////////////////////////////////////////////

  // request seen by the slave
  // setup is psel alone, access is psel with penable
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
  } apbReqT;

  // pready closes the access phase
  // pslverr and prdata are sampled on that same edge
  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apbRspT;

  //////////////////////////////////////////////////
  // generator side
  //////////////////////////////////////////////////

  // one random word as it leaves the cipher
  typedef logic [31:0] randWordT;

  // configuration handed from the register block to the datapath
  typedef struct packed {
    logic        enable;
    logic [1:0]  rounds;
    logic        seedLoad;
    logic [63:0] seed;
  } genCfgT;

  // occupancy of the word queue
  typedef struct packed {
    logic [2:0] count;
    logic       empty;
    logic       full;
  } fifoStatT;

endpackage

// File: lfsrCipher/cipherRound.sv
module cipherRound (
  input  logic [63:0] state_i,
  output logic [63:0] state_o
);

  // present s-box, indexed by the input nibble
  localparam logic [3:0] sBox [16] = '{
    4'hC, 4'h5, 4'h6, 4'hB,
    4'h9, 4'h0, 4'hA, 4'hD,
    4'h3, 4'hE, 4'hF, 4'h8,
    4'h4, 4'h7, 4'h1, 4'h2
  };

  logic [63:0] subst;

  //////////////////////////////////////////////////
  // substitution layer
  //////////////////////////////////////////////////

  // sixteen nibbles, each through the same box
  always_comb begin
    for (int n = 0; n < 16; n++) begin
      subst[4*n +: 4] = sBox[state_i[4*n +: 4]];
    end
  end

  //////////////////////////////////////////////////
  // permutation layer
  //////////////////////////////////////////////////

  // bit i moves to 16*i mod 63
  // bit 63 stays where it is
  always_comb begin
    state_o[63] = subst[63];
    for (int i = 0; i < 63; i++) begin
      state_o[(16 * i) % 63] = subst[i];
    end
  end

  // no key is mixed in, one round is only s-box and shuffle

endmodule

// File: lfsrCipher/lfsrCipher.sv
`include "prng_consts.svh"

module lfsrCipher (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  prngPkg::genCfgT   genCfg_i,
  input  logic              pushReady_i,
  output logic              pushValid_o,
  output prngPkg::randWordT word_o
);

  // galois shift, taps folded in when bit 0 falls out
  function automatic logic [63:0] galoisStep(logic [63:0] s);
    return (s >> 1) ^ ({64{s[0]}} & `PRNG_LFSR_MASK);
  endfunction

  // state stage, holds a stepped value not yet turned into a word
  logic [63:0]       state_q;
  logic [1:0]        stateRounds_q;
  logic              stateVld_q;

  // output stage
  logic              outVld_q;
  prngPkg::randWordT outWord_q;

  logic              outAdvance;
  logic              stateStep;
  logic [63:0]       roundState [`PRNG_MAX_ROUNDS+1];

  // output takes a new word when empty or when the queue accepts the old one
  assign outAdvance = genCfg_i.enable & (!outVld_q | pushReady_i);
  // state moves on once its value has been handed over
  assign stateStep  = genCfg_i.enable & (!stateVld_q | outAdvance);

  //////////////////////////////////////////////////
  // cipher chain
  //////////////////////////////////////////////////

  assign roundState[0] = state_q;

  for (genvar i = 0; i < `PRNG_MAX_ROUNDS; i++) begin : gRound
    cipherRound uRound (
      .state_i (roundState[i]),
      .state_o (roundState[i+1])
    );
  end

  //////////////////////////////////////////////////
  // state stage
  //////////////////////////////////////////////////

  // seed enters already stepped once so the first word is f(step(seed))
  // round count is captured together with each step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= '1;
      stateRounds_q <= '0;
      stateVld_q    <= 1'b0;
    end else if (genCfg_i.seedLoad) begin
      state_q       <= galoisStep(genCfg_i.seed);
      stateRounds_q <= genCfg_i.rounds;
      stateVld_q    <= 1'b1;
    end else if (stateStep) begin
      state_q       <= galoisStep(state_q);
      stateRounds_q <= genCfg_i.rounds;
      stateVld_q    <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////

  // a seed load drops the held word of the old sequence
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outVld_q <= 1'b0;
    end else if (genCfg_i.seedLoad) begin
      outVld_q <= 1'b0;
    end else if (outAdvance) begin
      outVld_q <= stateVld_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (outAdvance) begin
      outWord_q <= roundState[stateRounds_q][31:0];
    end
  end

  // pipeline freezes while disabled
  assign pushValid_o = outVld_q & genCfg_i.enable;
  assign word_o      = outWord_q;

  stateNonZero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q != '0);

  // a stalled word waits unchanged for the queue
  wordHeld: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outVld_q && !pushReady_i && !genCfg_i.seedLoad |=> outVld_q && $stable(outWord_q));

endmodule

// File: design/resultFifo.sv
`include "prng_consts.svh"

module resultFifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              pushValid_i,
  input  prngPkg::randWordT pushWord_i,
  output logic              pushReady_o,
  input  logic              pop_i,
  input  logic              flush_i,
  output prngPkg::randWordT headWord_o,
  output prngPkg::fifoStatT stat_o
);

  localparam int unsigned PtrW = $clog2(`PRNG_FIFO_DEPTH);

  prngPkg::randWordT mem [`PRNG_FIFO_DEPTH];
  logic [PtrW-1:0]   wrPtr_q;
  logic [PtrW-1:0]   rdPtr_q;
  logic [2:0]        count_q;
  logic              push;
  logic              pop;

  assign stat_o.count = count_q;
  assign stat_o.empty = count_q == '0;
  assign stat_o.full  = count_q == 3'(`PRNG_FIFO_DEPTH);

  assign pushReady_o = !stat_o.full;
  assign push        = pushValid_i & pushReady_o;
  assign pop         = pop_i & !stat_o.empty;

  // head is read straight out of the buffer
  assign headWord_o  = mem[rdPtr_q];

  // pointers wrap on their own since depth is a power of two
  // flush beats a push or pop in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wrPtr_q <= '0;
      rdPtr_q <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      wrPtr_q <= '0;
      rdPtr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wrPtr_q <= wrPtr_q + PtrW'(1);
      end
      if (pop) begin
        rdPtr_q <= rdPtr_q + PtrW'(1);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 3'd1;
        2'b01:   count_q <= count_q - 3'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wrPtr_q] <= pushWord_i;
    end
  end

  // full queue with no pop or flush takes nothing in
  noPushWhenFull: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stat_o.full && !pop_i && !flush_i |=> stat_o.full && $stable(wrPtr_q));

  countInRange: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= 3'(`PRNG_FIFO_DEPTH));

endmodule

// File: design/regDecode.sv
`include "prng_consts.svh"

module regDecode (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  prngPkg::apbReqT   apbReq_i,
  output prngPkg::apbRspT   apbRsp_o,
  output prngPkg::genCfgT   genCfg_o,
  input  prngPkg::fifoStatT fifoStat_i,
  input  prngPkg::randWordT headWord_i,
  output logic              pop_o,
  output logic              flush_o
);

  // ctrl register and staged seed half
  logic        enable_q;
  logic [1:0]  rounds_q;
  logic [31:0] seedLo_q;

  logic        access;
  logic        isCtrl;
  logic        isSeedLo;
  logic        isSeedHi;
  logic        isStatus;
  logic        isData;
  logic        badAddr;
  logic        dataRead;
  logic        stall;
  logic        wrDone;
  logic [63:0] seedNew;
  logic        seedZero;
  logic        seedAccept;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  assign access   = apbReq_i.psel & apbReq_i.penable;
  assign isCtrl   = apbReq_i.paddr == `PRNG_CTRL_ADDR;
  assign isSeedLo = apbReq_i.paddr == `PRNG_SEEDLO_ADDR;
  assign isSeedHi = apbReq_i.paddr == `PRNG_SEEDHI_ADDR;
  assign isStatus = apbReq_i.paddr == `PRNG_STATUS_ADDR;
  assign isData   = apbReq_i.paddr == `PRNG_DATA_ADDR;
  assign badAddr  = !(isCtrl | isSeedLo | isSeedHi | isStatus | isData);

  // data read waits only while a word can still arrive
  assign dataRead = access & isData & !apbReq_i.pwrite;
  assign stall    = dataRead & fifoStat_i.empty & enable_q;

  // writes always complete in the access cycle
  assign wrDone   = access & apbReq_i.pwrite;

  // full seed as it would be loaded by this seedhi write
  assign seedNew    = {apbReq_i.pwdata, seedLo_q};
  assign seedZero   = seedNew == '0;
  assign seedAccept = wrDone & isSeedHi & !seedZero;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  always_comb begin
    apbRsp_o.pready  = access & !stall;
    apbRsp_o.pslverr = 1'b0;
    apbRsp_o.prdata  = '0;
    if (access) begin
      if (badAddr) begin
        apbRsp_o.pslverr = 1'b1;
      end else if (apbReq_i.pwrite) begin
        // read-only registers and an all-zero seed are refused
        apbRsp_o.pslverr = isStatus | isData | (isSeedHi & seedZero);
      end else if (isCtrl) begin
        apbRsp_o.prdata = {29'b0, rounds_q, enable_q};
      end else if (isStatus) begin
        apbRsp_o.prdata = {29'b0, fifoStat_i.count};
      end else if (isData) begin
        if (!fifoStat_i.empty) begin
          apbRsp_o.prdata = headWord_i;
        end else begin
          // nothing queued and nothing coming
          apbRsp_o.pslverr = !enable_q;
        end
      end
      // seed halves read back as zero
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
      rounds_q <= '0;
      seedLo_q <= '0;
    end else if (wrDone) begin
      if (isCtrl) begin
        enable_q <= apbReq_i.pwdata[0];
        rounds_q <= apbReq_i.pwdata[2:1];
      end
      if (isSeedLo) begin
        seedLo_q <= apbReq_i.pwdata;
      end
    end
  end

  // seed load is a one-cycle pulse since writes never wait
  assign genCfg_o.enable   = enable_q;
  assign genCfg_o.rounds   = rounds_q;
  assign genCfg_o.seedLoad = seedAccept;
  assign genCfg_o.seed     = seedNew;

  // pop on the completing data read edge only
  assign pop_o   = dataRead & apbRsp_o.pready & !apbRsp_o.pslverr;
  // a new seed throws away words of the old sequence
  assign flush_o = seedAccept;

  // the queue must never see a pop while it reports empty
  popNotEmpty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_o |-> !fifoStat_i.empty);

endmodule

// File: design/prngTop.sv
module prngTop (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  prngPkg::apbReqT apbReq_i,
  output prngPkg::apbRspT apbRsp_o
);

  // register block to datapath
  prngPkg::genCfgT   genCfg;

  // datapath to queue handshake
  logic              pushValid;
  logic              pushReady;
  prngPkg::randWordT pushWord;

  // queue back to the register block
  logic              pop;
  logic              flush;
  prngPkg::fifoStatT fifoStat;
  prngPkg::randWordT headWord;

  // apb slave, control register and data port
  regDecode uRegDecode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .apbReq_i   (apbReq_i),
    .apbRsp_o   (apbRsp_o),
    .genCfg_o   (genCfg),
    .fifoStat_i (fifoStat),
    .headWord_i (headWord),
    .pop_o      (pop),
    .flush_o    (flush)
  );

  // lfsr plus optional cipher rounds
  lfsrCipher uLfsrCipher (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .genCfg_i    (genCfg),
    .pushReady_i (pushReady),
    .pushValid_o (pushValid),
    .word_o      (pushWord)
  );

  // words wait here until software reads them
  resultFifo uResultFifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pushValid_i (pushValid),
    .pushWord_i  (pushWord),
    .pushReady_o (pushReady),
    .pop_i       (pop),
    .flush_i     (flush),
    .headWord_o  (headWord),
    .stat_o      (fifoStat)
  );

endmodule

// File: testbench/tbClock.sv
module tbClock (
  output logic clk_o,
  output logic rst_no
);

  // free running clock, period of 20
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // reset low for three rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: testbench/prngTb.sv
`include "prng_consts.svh"

module prngTb;

  // row kinds and how a read result is judged
  localparam int OpRead   = 0;
  localparam int OpWrite  = 1;
  localparam int OpIdle   = 2;
  localparam int ChkNone  = 0;
  localparam int ChkValue = 1;
  localparam int ChkModel = 2;

  // present s-box, nibble n of this constant is the image of n
  localparam logic [63:0] SboxTable = 64'h21748FE3DA09B65C;

  logic            clk;
  logic            rstN;
  prngPkg::apbReqT apbReq;
  prngPkg::apbRspT apbRsp;

  // stimulus table, one row per index
  string       tName [$];
  int          tOp   [$];
  logic [4:0]  tAddr [$];
  logic [31:0] tData [$];
  bit          tRand [$];
  int          tChk  [$];
  logic [31:0] tExp  [$];
  bit          tErr  [$];
  bit          tableReady;

  // reference model
  logic [63:0] refState;
  logic [31:0] refSeedLo;
  logic [1:0]  refRounds;

  int errors;
  int passed;

  tbClock uClock (
    .clk_o  (clk),
    .rst_no (rstN)
  );

  prngTop dut (
    .clk_i    (clk),
    .rst_ni   (rstN),
    .apbReq_i (apbReq),
    .apbRsp_o (apbRsp)
  );

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // shift right, fold the taps back in when a one drops out
  function automatic logic [63:0] lfsrNext(logic [63:0] s);
    logic [63:0] n;
    n = {1'b0, s[63:1]};
    if (s[0]) begin
      n = n ^ `PRNG_LFSR_MASK;
    end
    return n;
  endfunction

  function automatic logic [63:0] presentRound(logic [63:0] s);
    logic [63:0] sub;
    logic [63:0] perm;
    for (int n = 0; n < 16; n++) begin
      sub[4*n +: 4] = SboxTable[4*int'(s[4*n +: 4]) +: 4];
    end
    // bit k of nibble j lands at 16*k + j
    for (int b = 0; b < 64; b++) begin
      perm[16*(b%4) + b/4] = sub[b];
    end
    return perm;
  endfunction

  function automatic logic [31:0] cipherWord(logic [63:0] s, logic [1:0] r);
    logic [63:0] t;
    t = s;
    for (int k = 0; k < int'(r); k++) begin
      t = presentRound(t);
    end
    return t[31:0];
  endfunction

  // register side effects of a write, seen from software
  task automatic trackWrite(input logic [4:0] addr, input logic [31:0] data);
    if (addr == `PRNG_CTRL_ADDR) begin
      refRounds = data[2:1];
    end else if (addr == `PRNG_SEEDLO_ADDR) begin
      refSeedLo = data;
    end else if (addr == `PRNG_SEEDHI_ADDR && {data, refSeedLo} != 64'h0) begin
      refState = {data, refSeedLo};
    end
  endtask

  //////////////////////////////////////////////////
  // apb driver
  //////////////////////////////////////////////////

  // drive on falling edges, sample on the rising edge with pready
  task automatic apbTransfer(input bit write, input logic [4:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err, output int waits);
    @(negedge clk);
    apbReq.psel    = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite  = write;
    apbReq.paddr   = addr;
    apbReq.pwdata  = wdata;
    @(negedge clk);
    apbReq.penable = 1'b1;
    waits = 0;
    @(posedge clk);
    while (!apbRsp.pready) begin
      waits++;
      @(posedge clk);
    end
    rdata = apbRsp.prdata;
    err   = apbRsp.pslverr;
  endtask

  task automatic idleCycles(input int n);
    @(negedge clk);
    apbReq.psel    = 1'b0;
    apbReq.penable = 1'b0;
    repeat (n) @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  function void addTest(string name, int op, logic [4:0] addr, logic [31:0] data,
                        bit rnd, int chk, logic [31:0] exp, bit err);
    tName.push_back(name);
    tOp.push_back(op);
    tAddr.push_back(addr);
    tData.push_back(data);
    tRand.push_back(rnd);
    tChk.push_back(chk);
    tExp.push_back(exp);
    tErr.push_back(err);
  endfunction

  // random seed, high half forced odd so the seed is never zero
  task automatic addSeed(string name);
    addTest({name, " lo"}, OpWrite, `PRNG_SEEDLO_ADDR, 32'h0, 1'b1, ChkNone, 32'h0, 1'b0);
    addTest({name, " hi"}, OpWrite, `PRNG_SEEDHI_ADDR, 32'h1, 1'b1, ChkNone, 32'h0, 1'b0);
  endtask

  task automatic buildTable();
    // reset state and plain registers
    addTest("status reset", OpRead, `PRNG_STATUS_ADDR, 32'h0, 1'b0, ChkValue, 32'h0, 1'b0);
    addTest("ctrl write", OpWrite, `PRNG_CTRL_ADDR, 32'h5, 1'b0, ChkNone, 32'h0, 1'b0);
    addTest("ctrl readback", OpRead, `PRNG_CTRL_ADDR, 32'h0, 1'b0, ChkValue, 32'h5, 1'b0);
    addTest("seedlo write", OpWrite, `PRNG_SEEDLO_ADDR, 32'hA5A51234, 1'b0, ChkNone, 32'h0,
            1'b0);
    addTest("seedlo read", OpRead, `PRNG_SEEDLO_ADDR, 32'h0, 1'b0, ChkValue, 32'h0, 1'b0);
    addTest("seedhi read", OpRead, `PRNG_SEEDHI_ADDR, 32'h0, 1'b0, ChkValue, 32'h0, 1'b0);
    // bare lfsr, no rounds
    addTest("ctrl rounds 0", OpWrite, `PRNG_CTRL_ADDR, 32'h1, 1'b0, ChkNone, 32'h0, 1'b0);
    addSeed("seed raw");
    for (int i = 0; i < 8; i++) begin
      addTest("raw word", OpRead, `PRNG_DATA_ADDR, 32'h0, 1'b0, ChkModel, 32'h0, 1'b0);
    end
    // one and three cipher rounds
    addTest("ctrl rounds 1", OpWrite, `PRNG_CTRL_ADDR, 32'h3, 1'b0, ChkNone, 32'h0, 1'b0);
    addSeed("seed r1");
    for (int i = 0; i < 4; i++) begin
      addTest("r1 word", OpRead, `PRNG_DATA_ADDR, 32'h0, 1'b0, ChkModel, 32'h0, 1'b0);
    end
    addTest("ctrl rounds 3", OpWrite, `PRNG_CTRL_ADDR, 32'h7, 1'b0, ChkNone, 32'h0, 1'b0);
    addSeed("seed r3");
    for (int i = 0; i < 4; i++) begin
      addTest("r3 word", OpRead, `PRNG_DATA_ADDR, 32'h0, 1'b0, ChkModel, 32'h0, 1'b0);
    end
    // queue fills up, generator stalls behind it
    addTest("wait for fill", OpIdle, 5'h0, 32'd10, 1'b0, ChkNone, 32'h0, 1'b0);
    addTest("status full", OpRead, `PRNG_STATUS_ADDR, 32'h0, 1'b0, ChkValue, 32'h4, 1'b0);
    for (int i = 0; i < 6; i++) begin
      addTest("full word", OpRead, `PRNG_DATA_ADDR, 32'h0, 1'b0, ChkModel, 32'h0, 1'b0);
    end
    // zero seed is refused and the old sequence runs on
    addTest("seedlo zero", OpWrite, `PRNG_SEEDLO_ADDR, 32'h0, 1'b0, ChkNone, 32'h0, 1'b0);
    addTest("seedhi zero", OpWrite, `PRNG_SEEDHI_ADDR, 32'h0, 1'b0, ChkNone, 32'h0, 1'b1);
    for (int i = 0; i < 3; i++) begin
      addTest("zero seed word", OpRead, `PRNG_DATA_ADDR, 32'h0, 1'b0, ChkModel, 32'h0, 1'b0);
    end
    // unmapped and read-only targets
    addTest("read bad addr", OpRead, 5'h14, 32'h0, 1'b0, ChkNone, 32'h0, 1'b1);
    addTest("write bad addr", OpWrite, 5'h1C, 32'h1, 1'b0, ChkNone, 32'h0, 1'b1);
    addTest("write status", OpWrite, `PRNG_STATUS_ADDR, 32'h1, 1'b0, ChkNone, 32'h0, 1'b1);
    addTest("write data", OpWrite, `PRNG_DATA_ADDR, 32'h1, 1'b0, ChkNone, 32'h0, 1'b1);
    addTest("bad write word", OpRead, `PRNG_DATA_ADDR, 32'h0, 1'b0, ChkModel, 32'h0, 1'b0);
    // disabled, seed load empties the queue, nothing comes
    addTest("ctrl disable", OpWrite, `PRNG_CTRL_ADDR, 32'h6, 1'b0, ChkNone, 32'h0, 1'b0);
    addSeed("seed off");
    addTest("data disabled", OpRead, `PRNG_DATA_ADDR, 32'h0, 1'b0, ChkValue, 32'h0, 1'b1);
    addTest("ctrl enable", OpWrite, `PRNG_CTRL_ADDR, 32'h7, 1'b0, ChkNone, 32'h0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      addTest("reenable word", OpRead, `PRNG_DATA_ADDR, 32'h0, 1'b0, ChkModel, 32'h0, 1'b0);
    end
    // reseed over a filled queue
    addTest("wait for queue", OpIdle, 5'h0, 32'd6, 1'b0, ChkNone, 32'h0, 1'b0);
    addSeed("seed flush");
    for (int i = 0; i < 4; i++) begin
      addTest("flush word", OpRead, `PRNG_DATA_ADDR, 32'h0, 1'b0, ChkModel, 32'h0, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////
  // run
  //////////////////////////////////////////////////

  initial begin : mainFlow
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] expVal;
    logic        err;
    int          waits;
    bit          ok;

    apbReq     = '0;
    errors     = 0;
    passed     = 0;
    tableReady = 1'b0;
    refState   = '1;
    refSeedLo  = '0;
    refRounds  = '0;
    void'($urandom(7));
    buildTable();
    tableReady = 1'b1;
    wait (rstN === 1'b1);

    for (int i = 0; i < tName.size(); i++) begin
      ok    = 1'b1;
      wdata = tData[i];
      if (tRand[i]) begin
        wdata = $urandom() | tData[i];
      end
      if (tOp[i] == OpIdle) begin
        idleCycles(int'(tData[i]));
      end else begin
        apbTransfer(tOp[i] == OpWrite, tAddr[i], wdata, rdata, err, waits);
        expVal = tExp[i];
        if (tOp[i] == OpWrite) begin
          trackWrite(tAddr[i], wdata);
        end else if (tChk[i] == ChkModel) begin
          // next word is f of the next state
          refState = lfsrNext(refState);
          expVal   = cipherWord(refState, refRounds);
        end
        if (err !== tErr[i]) begin
          $display("** Error: %s pslverr expected %0d actual %0d", tName[i], tErr[i], err);
          ok = 1'b0;
        end
        if (tOp[i] == OpRead && tChk[i] != ChkNone && rdata !== expVal) begin
          $display("** Error: %s expected %h actual %h", tName[i], expVal, rdata);
          ok = 1'b0;
        end
        // only a data read may hold pready low
        if (waits != 0 && !(tOp[i] == OpRead && tAddr[i] == `PRNG_DATA_ADDR)) begin
          $display("%s was stretched by %0d wait cycles instead of taking two", tName[i],
                   waits);
          ok = 1'b0;
        end
      end
      if (ok) begin
        $display("pass: %s", tName[i]);
        passed++;
      end else begin
        errors++;
      end
    end

    idleCycles(1);
    $display("%0d tests run, %0d passed, %0d failed", tName.size(), passed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // generous budget per row, stalled reads included
  initial begin : watchdog
    wait (tableReady);
    repeat (200 * tName.size()) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run is stuck", 200 * tName.size());
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: sim.f
+incdir+common
common/prngPkg.sv
lfsrCipher/cipherRound.sv
lfsrCipher/lfsrCipher.sv
design/resultFifo.sv
design/regDecode.sv
design/prngTop.sv
testbench/tbClock.sv
testbench/prngTb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f sim.f --top-module prngTb -o prngSim
	@out="$$(./obj_dir/prngSim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
